// File: testbench/acortex_tests.txt
# test  command     arg_a  arg_b     all values hex
# REG_WR addr data, REG_RD addr expected (CAP_DATA compares with the captured frame)
# ADC_FRAME pairs frame_pulses, CREDITS count, ANA_RD word, EXPECT_DAC pairs
regs    REG_RD      01     00000000
regs    REG_RD      00     00000000
regs    REG_WR      00     00000001
regs    REG_RD      00     00000001
regs    REG_WR      00     00000000
regs    REG_RD      00     00000000
regs    REG_RD      07     deadbabe
regs    REG_WR      02     00000005
regs    REG_RD      02     00000005
ana     ADC_FRAME   08     01
ana     ANA_RD      00     00
ana     ANA_RD      05     00
ana     ANA_RD      0f     00
play    CREDITS     04     00
play    EXPECT_DAC  04     00
play    CREDITS     04     00
play    EXPECT_DAC  04     00
play    CREDITS     02     00
play    EXPECT_DAC  00     00
bkpr    ADC_FRAME   08     01
bkpr    EXPECT_DAC  02     00
bkpr    CREDITS     03     00
bkpr    EXPECT_DAC  03     00
bkpr    CREDITS     03     00
bkpr    EXPECT_DAC  03     00
cap     REG_WR      00     00000001
cap     ADC_FRAME   0a     01
cap     REG_RD      01     00000001
cap     REG_WR      02     00000000
cap     REG_RD      03     00000000
cap     REG_WR      02     00000007
cap     REG_RD      03     00000000
cap     REG_WR      02     0000000f
cap     REG_RD      03     00000000
cap     ANA_RD      00     00
ret     REG_WR      00     00000000
ret     REG_RD      01     00000000
ret     ADC_FRAME   08     01
ret     CREDITS     08     00
ret     EXPECT_DAC  08     00

// File: acortex.f
+incdir+common
common/acortex_pkg.sv
pcm_bffr/pcm_dpram.sv
pcm_bffr/pcm_bffr.sv
source/pcm_dac_feeder.sv
source/acortex.sv
testbench/acortex_props.sv
testbench/acortex_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = acortex_tb
FILELIST = acortex.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/acortex_tb.sv
/*
  Testbench of the audio buffering core
  Command file stimulus, frame model, compare tasks,
  DAC and frame monitor, cycle watchdog and summary
*/
`timescale 1ns/100ps
`default_nettype none

module acortex_tb;
  import acortex_pkg::*;
  `include "pcm_bffr_regmap.svh"

  localparam int NUM_SAMPLES  = 8;
  localparam int MEM_RD_DELAY = 2;
  localparam int DAC_CREDITS  = 4;
  localparam int ANA_W        = $clog2(2*NUM_SAMPLES);
  localparam int FRAME_CYCLES = 4*NUM_SAMPLES + 16;      // Budget per command
  localparam int QUIET_CYCLES = 4*(MEM_RD_DELAY+2) + 8;  // Window for stray pairs

  logic             clk = 1'b0;
  logic             rst_n;
  lb_req_t          lb_req;
  lb_rsp_t          lb_rsp;
  logic             adc_valid;
  pcm_pair_t        adc_pair;
  logic             dac_credit;
  logic             dac_valid;
  pcm_pair_t        dac_pair;
  logic [ANA_W-1:0] ana_addr;
  pcm_word_t        ana_data;
  logic             ana_frame_rdy;

  string    name_q [$];  // Command file columns
  string    cmd_q [$];
  lb_data_t arg_a_q [$];
  lb_data_t arg_b_q [$];

  pcm_pair_t        exp_frame [NUM_SAMPLES];  // Latest complete frame
  pcm_pair_t        dac_q [$];                // Pairs seen at the DAC
  bffr_mode_e       mode_m;
  logic             cap_done_m;
  logic [ANA_W-1:0] cap_addr_m;
  int               play_idx;   // Next pair expected at the DAC
  int               granted;
  int               received;
  int               frame_cnt;
  int               errors;
  int               checks;
  int               cycles;
  int               cycle_limit;
  int               tests_run;
  int               tests_failed;
  int               test_errs;  // Error count at test start
  string            cur_test;

  always #20 clk = ~clk;  // 40 ns period

  acortex #(
    .NUM_SAMPLES  (NUM_SAMPLES),
    .MEM_RD_DELAY (MEM_RD_DELAY),
    .DAC_CREDITS  (DAC_CREDITS)
  ) acortex_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lb_req        (lb_req),
    .lb_rsp        (lb_rsp),
    .adc_valid     (adc_valid),
    .adc_pair      (adc_pair),
    .dac_credit    (dac_credit),
    .dac_valid     (dac_valid),
    .dac_pair      (dac_pair),
    .ana_addr      (ana_addr),
    .ana_data      (ana_data),
    .ana_frame_rdy (ana_frame_rdy)
  );

  bind acortex acortex_props props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .dac_credit (dac_credit),
    .dac_valid  (dac_valid),
    .play_req   (play_req),
    .lb_req     (lb_req),
    .lb_rsp     (lb_rsp)
  );

  task automatic check_word(input string what, input lb_data_t exp, input lb_data_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch in %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_pair(input string what, input pcm_pair_t exp, input pcm_pair_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch in %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input bit exp, input bit act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch in %s: %s expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  // Word 2i is left, 2i+1 right of pair i
  function automatic pcm_word_t frame_word(input logic [ANA_W-1:0] word);
    return word[0] ? exp_frame[word[ANA_W-1:1]].right : exp_frame[word[ANA_W-1:1]].left;
  endfunction

  task automatic reg_write(input lb_addr_t addr, input lb_data_t data);
    @(posedge clk);
    lb_req.wr_en   <= 1'b1;
    lb_req.addr    <= addr;
    lb_req.wr_data <= data;
    @(posedge clk);
    lb_req.wr_en <= 1'b0;
    @(negedge clk);
    check_flag($sformatf("wr_valid after write to %0h", addr), 1'b1, lb_rsp.wr_valid);
  endtask

  task automatic reg_read(input lb_addr_t addr, output lb_data_t data);
    int latency;
    int waited;
    latency = (addr == PCM_BFFR_CAP_DATA_ADDR) ? MEM_RD_DELAY : 1;  // CAP_DATA waits for RAM
    waited  = 1;
    @(posedge clk);
    lb_req.rd_en <= 1'b1;
    lb_req.addr  <= addr;
    @(posedge clk);
    lb_req.rd_en <= 1'b0;
    @(negedge clk);
    while (!lb_rsp.rd_valid)
    begin
      @(negedge clk);
      waited++;
    end
    check_word($sformatf("rd_valid latency of %0h", addr), lb_data_t'(latency),
               lb_data_t'(waited));
    data = lb_rsp.rd_data;
  endtask

  task automatic send_adc(input int pairs, input int frames_exp);
    pcm_pair_t pair;
    logic      take;
    take      = !(mode_m == MODE_CAPTURE && cap_done_m);  // Frozen capture drops all
    frame_cnt = 0;
    for (int i = 0; i < pairs; i++)
    begin
      pair.left  = $urandom;
      pair.right = $urandom;
      if (take && i < NUM_SAMPLES)
        exp_frame[i] = pair;
      @(posedge clk);
      adc_valid <= 1'b1;
      adc_pair  <= pair;
      @(posedge clk);
      adc_valid <= 1'b0;  // Two-cycle spacing
    end
    if (take && pairs >= NUM_SAMPLES)
    begin
      cap_done_m = (mode_m == MODE_CAPTURE);
      play_idx   = 0;  // Swap restarts playback
    end
    repeat (3) @(negedge clk);
    check_word("frame ready pulses", lb_data_t'(frames_exp), lb_data_t'(frame_cnt));
  endtask

  task automatic give_credits(input int count);
    for (int i = 0; i < count; i++)
    begin
      while (granted - received >= DAC_CREDITS)  // Sink limit
        @(negedge clk);
      @(posedge clk);
      dac_credit <= 1'b1;
      granted++;
      @(posedge clk);
      dac_credit <= 1'b0;
    end
  endtask

  task automatic expect_dac(input int count);
    pcm_pair_t pair;
    for (int i = 0; i < count; i++)
    begin
      while (dac_q.size() == 0)
        @(negedge clk);
      pair = dac_q.pop_front();
      if (play_idx >= NUM_SAMPLES)
      begin
        errors++;
        $display("%s: DAC pair arrived beyond the end of the frame", cur_test);
      end
      else
        check_pair($sformatf("DAC pair %0d", play_idx), exp_frame[play_idx], pair);
      play_idx++;
    end
    repeat (QUIET_CYCLES) @(negedge clk);
    check_word("extra DAC pairs", '0, lb_data_t'(dac_q.size()));
    dac_q.delete();
  endtask

  task automatic read_analyzer(input logic [ANA_W-1:0] word);
    @(posedge clk);
    ana_addr <= word;
    repeat (MEM_RD_DELAY) @(posedge clk);
    @(negedge clk);
    check_word($sformatf("analyzer word %0h", word), frame_word(word), ana_data);
  endtask

  task automatic run_command(input string cmd, input lb_data_t a, input lb_data_t b);
    lb_data_t data;
    lb_data_t exp;
    if (cmd == "REG_WR")
    begin
      reg_write(lb_addr_t'(a), b);
      if (lb_addr_t'(a) == PCM_BFFR_CONTROL_ADDR)
      begin
        mode_m     = bffr_mode_e'(b[0]);
        cap_done_m = 1'b0;  // Frame restarts in bank A
      end
      else if (lb_addr_t'(a) == PCM_BFFR_CAP_ADDR_ADDR)
        cap_addr_m = b[ANA_W-1:0];
    end
    else if (cmd == "REG_RD")
    begin
      reg_read(lb_addr_t'(a), data);
      exp = (lb_addr_t'(a) == PCM_BFFR_CAP_DATA_ADDR) ? frame_word(cap_addr_m) : b;
      check_word($sformatf("register %0h", a), exp, data);
    end
    else if (cmd == "ADC_FRAME")
      send_adc(int'(a), int'(b));
    else if (cmd == "CREDITS")
      give_credits(int'(a));
    else if (cmd == "ANA_RD")
      read_analyzer(a[ANA_W-1:0]);
    else if (cmd == "EXPECT_DAC")
      expect_dac(int'(a));
    else
    begin
      errors++;
      $display("%s: unknown command %s in the test file", cur_test, cmd);
    end
  endtask

  task automatic report_test();
    tests_run++;
    if (errors == test_errs)
      $display("test %s passed", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - test_errs);
    end
  endtask

  // DAC and frame monitor sampled mid-cycle
  always @(negedge clk)
  begin
    if (dac_valid)
    begin
      dac_q.push_back(dac_pair);
      received++;
    end
    if (ana_frame_rdy)
      frame_cnt++;
  end

  initial
  begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_limit);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    int       fd;
    string    line;
    string    tname;
    string    cmd;
    lb_data_t a;
    lb_data_t b;
    void'($urandom(32'h62df_68e5));  // One seed for the run
    rst_n      <= 1'b0;
    lb_req     <= '0;
    adc_valid  <= 1'b0;
    adc_pair   <= '0;
    dac_credit <= 1'b0;
    ana_addr   <= '0;
    mode_m     = MODE_PLAY;
    cap_done_m = 1'b0;
    cap_addr_m = '0;
    fd = $fopen("testbench/acortex_tests.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("cannot open the test file testbench/acortex_tests.txt");
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.getc(0) != "#" && $sscanf(line, "%s %s %h %h", tname, cmd, a, b) == 4)
        begin
          name_q.push_back(tname);
          cmd_q.push_back(cmd);
          arg_a_q.push_back(a);
          arg_b_q.push_back(b);
        end
      end
      $fclose(fd);
    end
    cycle_limit = name_q.size() * FRAME_CYCLES;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < name_q.size(); i++)
    begin
      if (name_q[i] != cur_test)
      begin
        if (cur_test != "")
          report_test();
        cur_test  = name_q[i];
        test_errs = errors;
      end
      run_command(cmd_q[i], arg_a_q[i], arg_b_q[i]);
    end
    if (cur_test != "")
      report_test();
    $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/acortex_props.sv
/*
  Bound checks on the audio buffering core
  DAC credit use, play request spacing, local-bus read responses
*/
`timescale 1ns/100ps
`default_nettype none

module acortex_props (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 dac_credit,
  input logic                 dac_valid,
  input logic                 play_req,
  input acortex_pkg::lb_req_t lb_req,
  input acortex_pkg::lb_rsp_t lb_rsp
);

  int credits_open;  // Credits not yet used by a pair
  int reads_open;    // Reads still owed a response

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credits_open <= 0;
      reads_open   <= 0;
    end
    else
    begin
      credits_open <= credits_open + int'(dac_credit) - int'(dac_valid);
      reads_open   <= reads_open + int'(lb_req.rd_en) - int'(lb_rsp.rd_valid);
    end
  end

  // Every pair at the DAC uses up one credit
  dac_needs_credit: assert property (
    @(posedge clk) disable iff (!rst_n) dac_valid |-> credits_open > 0
  ) else $error("dac_valid with no credit left");

  play_req_gap: assert property (
    @(posedge clk) disable iff (!rst_n) play_req |=> !play_req
  ) else $error("play_req in two consecutive cycles");

  // Response only for a read already issued
  rd_valid_after_rd_en: assert property (
    @(posedge clk) disable iff (!rst_n) lb_rsp.rd_valid |-> reads_open > 0
  ) else $error("rd_valid without an open read");

endmodule

`default_nettype wire

// File: source/acortex.sv
/*
  Audio buffering core top level
  Two-bank PCM buffer joined to the DAC playback feeder
*/
`timescale 1ns/100ps
`default_nettype none

module acortex #(
  parameter int NUM_SAMPLES  = 128,  // Pairs per bank
  parameter int MEM_RD_DELAY = 2,    // RAM read latency, at least 1
  parameter int DAC_CREDITS  = 4     // Credit limit of the feeder
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  acortex_pkg::lb_req_t             lb_req,
  output acortex_pkg::lb_rsp_t             lb_rsp,
  input  logic                             adc_valid,
  input  acortex_pkg::pcm_pair_t           adc_pair,
  input  logic                             dac_credit,
  output logic                             dac_valid,
  output acortex_pkg::pcm_pair_t           dac_pair,
  input  logic [$clog2(2*NUM_SAMPLES)-1:0] ana_addr,
  output acortex_pkg::pcm_word_t           ana_data,
  output logic                             ana_frame_rdy
);
  import acortex_pkg::*;

  logic      play_rdy;    // Buffer can take a request
  logic      play_req;    // Feeder pulls one pair
  logic      play_valid;
  pcm_pair_t play_pair;

  pcm_bffr #(
    .NUM_SAMPLES  (NUM_SAMPLES),
    .MEM_RD_DELAY (MEM_RD_DELAY)
  ) bffr_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lb_req        (lb_req),
    .lb_rsp        (lb_rsp),
    .adc_valid     (adc_valid),
    .adc_pair      (adc_pair),
    .play_req      (play_req),
    .play_rdy      (play_rdy),
    .play_valid    (play_valid),
    .play_pair     (play_pair),
    .ana_addr      (ana_addr),
    .ana_data      (ana_data),
    .ana_frame_rdy (ana_frame_rdy)
  );

  pcm_dac_feeder #(
    .DAC_CREDITS (DAC_CREDITS)
  ) feeder_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .dac_credit (dac_credit),
    .play_rdy   (play_rdy),
    .play_req   (play_req),
    .play_valid (play_valid),
    .play_pair  (play_pair),
    .dac_valid  (dac_valid),
    .dac_pair   (dac_pair)
  );

endmodule

`default_nettype wire

// File: source/pcm_dac_feeder.sv
/*
  DAC playback feeder
  Credit counter, play request issue, output pair register
*/
`timescale 1ns/100ps
`default_nettype none

module pcm_dac_feeder #(
  parameter int DAC_CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dac_credit,  // One per pair the sink can take
  input  logic                   play_rdy,
  output logic                   play_req,
  input  logic                   play_valid,
  input  acortex_pkg::pcm_pair_t play_pair,
  output logic                   dac_valid,
  output acortex_pkg::pcm_pair_t dac_pair
);

  localparam int CNT_W = $clog2(DAC_CREDITS + 1);

  typedef logic [CNT_W-1:0] credit_cnt_t;

  localparam credit_cnt_t MAX_CREDITS = credit_cnt_t'(DAC_CREDITS);

  credit_cnt_t credits;
  logic        credit_add;

  // Saturate at the credit limit
  assign credit_add = dac_credit & (credits != MAX_CREDITS);

  // Request charged at issue, the buffer spaces requests
  assign play_req = (credits != '0) & play_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credits <= '0;
    end
    else
    begin
      case ({credit_add, play_req})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;  // Both or neither
      endcase
    end
  end

  // Returned pair to the DAC one cycle later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dac_valid <= 1'b0;
    end
    else
    begin
      dac_valid <= play_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (play_valid)
    begin
      dac_pair <= play_pair;  // Held between pairs
    end
  end

endmodule

`default_nettype wire

// File: pcm_bffr/pcm_bffr.sv
/*
  Two-bank PCM buffer with analyzer mirror
  ADC write and play read address logic, read tag delay line,
  local-bus register block with capture mode
*/
`timescale 1ns/100ps
`default_nettype none

module pcm_bffr #(
  parameter int NUM_SAMPLES  = 128,
  parameter int MEM_RD_DELAY = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  acortex_pkg::lb_req_t             lb_req,
  output acortex_pkg::lb_rsp_t             lb_rsp,
  input  logic                             adc_valid,
  input  acortex_pkg::pcm_pair_t           adc_pair,
  input  logic                             play_req,
  output logic                             play_rdy,
  output logic                             play_valid,
  output acortex_pkg::pcm_pair_t           play_pair,
  input  logic [$clog2(2*NUM_SAMPLES)-1:0] ana_addr,
  output acortex_pkg::pcm_word_t           ana_data,
  output logic                             ana_frame_rdy
);
  import acortex_pkg::*;
  `include "pcm_bffr_regmap.svh"

  localparam int ADDR_W = $clog2(2*NUM_SAMPLES);  // Word address
  localparam int PTR_W  = ADDR_W - 1;             // Pair index
  localparam logic [ADDR_W-1:0] LAST_WORD = ADDR_W'(2*NUM_SAMPLES-1);
  localparam logic [PTR_W-1:0]  LAST_PAIR = PTR_W'(NUM_SAMPLES-1);

  // Travels with each RAM read until its data appears
  typedef struct packed {
    logic play;   // Playback word
    logic right;  // Right word of the pair
    logic bank;   // 0 is bank A
    logic cap;    // Capture read from the bus
  } rd_tag_t;

  bffr_mode_e        mode;
  logic              cap_done;
  logic [ADDR_W-1:0] cap_addr;
  logic              wr_valid_q;
  logic              rd_valid_q;
  lb_data_t          rd_data_q;
  logic [ADDR_W-1:0] wr_ptr;
  logic              wr_bank;         // Bank taking ADC data
  logic              adc_right_pend;  // Right word due this cycle
  pcm_word_t         adc_right_q;
  logic              play_act;        // Play bank holds unread pairs
  logic              play_bank;
  logic [PTR_W-1:0]  play_ptr;
  logic              play_req_1d;
  logic [PTR_W-1:0]  req_ptr_q;       // Pair of the pending right read
  logic              req_bank_q;
  pcm_word_t         left_q;
  rd_tag_t           tag_pipe [MEM_RD_DELAY];
  rd_tag_t           tag_in;
  rd_tag_t           tag_out;
  logic [ADDR_W-1:0] rd_addr;
  pcm_word_t         a_rd_data;
  pcm_word_t         b_rd_data;
  pcm_word_t         rd_word;
  pcm_word_t         wr_data;
  logic              wr_go;
  logic              adc_take;
  logic              frame_end;
  logic              swap;
  logic              ctrl_wr;
  logic              cap_rd;
  logic              play_take;

  assign ctrl_wr   = lb_req.wr_en & (lb_req.addr == PCM_BFFR_CONTROL_ADDR);
  assign cap_rd    = lb_req.rd_en & (lb_req.addr == PCM_BFFR_CAP_DATA_ADDR);
  assign adc_take  = adc_valid & ~((mode == MODE_CAPTURE) & cap_done);  // Frozen once captured
  assign wr_go     = adc_take | adc_right_pend;
  assign wr_data   = adc_take ? adc_pair.left : adc_right_q;
  assign frame_end = wr_go & (wr_ptr == LAST_WORD);  // Last right word of the bank
  assign swap      = frame_end & (mode == MODE_PLAY);
  assign play_rdy  = play_act & ~play_req_1d;  // Gap after each request
  assign play_take = play_req & play_rdy;

  // Register block
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mode       <= MODE_PLAY;
      cap_addr   <= '0;
      wr_valid_q <= 1'b0;
      rd_valid_q <= 1'b0;
    end
    else
    begin
      wr_valid_q <= lb_req.wr_en;
      rd_valid_q <= lb_req.rd_en & ~cap_rd;  // CAP_DATA answers from the tag line
      if (ctrl_wr)
        mode <= bffr_mode_e'(lb_req.wr_data[0]);
      if (lb_req.wr_en && lb_req.addr == PCM_BFFR_CAP_ADDR_ADDR)
        cap_addr <= lb_req.wr_data[ADDR_W-1:0];
    end
  end

  // Write side and frame completion
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr         <= '0;
      wr_bank        <= 1'b0;
      cap_done       <= 1'b0;
      adc_right_pend <= 1'b0;
      ana_frame_rdy  <= 1'b0;
    end
    else
    begin
      ana_frame_rdy <= frame_end;
      if (ctrl_wr)  // Restart in bank A
      begin
        wr_ptr         <= '0;
        wr_bank        <= 1'b0;
        cap_done       <= 1'b0;
        adc_right_pend <= 1'b0;
      end
      else
      begin
        adc_right_pend <= adc_take;
        if (wr_go)
          wr_ptr <= frame_end ? '0 : wr_ptr + 1'b1;
        if (swap)
          wr_bank <= ~wr_bank;
        if (frame_end && mode == MODE_CAPTURE)
          cap_done <= 1'b1;
      end
    end
  end

  // Play pointer, swap restarts it even mid-frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play_act    <= 1'b0;
      play_bank   <= 1'b0;
      play_ptr    <= '0;
      play_req_1d <= 1'b0;
      req_ptr_q   <= '0;
      req_bank_q  <= 1'b0;
    end
    else
    begin
      play_req_1d <= play_take;
      if (play_take)
      begin
        req_ptr_q  <= play_ptr;
        req_bank_q <= play_bank;
      end
      if (ctrl_wr)
        play_act <= 1'b0;
      else if (swap)
      begin
        play_act  <= 1'b1;
        play_bank <= wr_bank;  // Bank just filled
        play_ptr  <= '0;
      end
      else if (play_take)
      begin
        play_ptr <= play_ptr + 1'b1;
        if (play_ptr == LAST_PAIR)
          play_act <= 1'b0;  // Wait for the next swap
      end
    end
  end

  // Read address and tag, capture read first
  always_comb
  begin
    tag_in = '0;
    if (cap_rd)
    begin
      rd_addr    = cap_addr;
      tag_in.cap = 1'b1;
    end
    else if (play_req_1d)
    begin
      rd_addr      = {req_ptr_q, 1'b1};
      tag_in.play  = 1'b1;
      tag_in.right = 1'b1;
      tag_in.bank  = req_bank_q;
    end
    else
    begin
      rd_addr     = {play_ptr, 1'b0};
      tag_in.play = play_take;
      tag_in.bank = play_bank;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < MEM_RD_DELAY; i++)
        tag_pipe[i] <= '0;
    end
    else
    begin
      tag_pipe[0] <= tag_in;
      for (int i = 1; i < MEM_RD_DELAY; i++)
        tag_pipe[i] <= tag_pipe[i-1];
    end
  end

  assign tag_out = tag_pipe[MEM_RD_DELAY-1];  // Lines up with RAM output
  assign rd_word = tag_out.bank ? b_rd_data : a_rd_data;

  // Payload registers
  always_ff @(posedge clk)
  begin
    adc_right_q <= adc_pair.right;
    if (tag_out.play && !tag_out.right)
      left_q <= rd_word;
    case (lb_req.addr)
      PCM_BFFR_CONTROL_ADDR:  rd_data_q <= lb_data_t'(mode);
      PCM_BFFR_STATUS_ADDR:   rd_data_q <= lb_data_t'(cap_done);
      PCM_BFFR_CAP_ADDR_ADDR: rd_data_q <= lb_data_t'(cap_addr);
      default:                rd_data_q <= LB_BAD_DATA;
    endcase
  end

  assign play_valid      = tag_out.play & tag_out.right;
  assign play_pair.left  = left_q;
  assign play_pair.right = rd_word;  // Right word straight from RAM

  always_comb
  begin
    lb_rsp.wr_valid = wr_valid_q;
    lb_rsp.rd_valid = rd_valid_q | tag_out.cap;
    lb_rsp.rd_data  = tag_out.cap ? a_rd_data : rd_data_q;
  end

  pcm_dpram #(
    .NUM_SAMPLES  (NUM_SAMPLES),
    .MEM_RD_DELAY (MEM_RD_DELAY)
  ) bank_a_i (
    .clk     (clk),
    .wr_en   (wr_go & ~wr_bank),
    .wr_addr (wr_ptr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (a_rd_data)
  );

  pcm_dpram #(
    .NUM_SAMPLES  (NUM_SAMPLES),
    .MEM_RD_DELAY (MEM_RD_DELAY)
  ) bank_b_i (
    .clk     (clk),
    .wr_en   (wr_go & wr_bank),
    .wr_addr (wr_ptr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (b_rd_data)
  );

  // Mirror sees every word, read by the analyzer
  pcm_dpram #(
    .NUM_SAMPLES  (NUM_SAMPLES),
    .MEM_RD_DELAY (MEM_RD_DELAY)
  ) mirror_i (
    .clk     (clk),
    .wr_en   (wr_go),
    .wr_addr (wr_ptr),
    .wr_data (wr_data),
    .rd_addr (ana_addr),
    .rd_data (ana_data)
  );

endmodule

`default_nettype wire

// File: pcm_bffr/pcm_dpram.sv
/*
  Synchronous simple-dual-port RAM of PCM words
  2*NUM_SAMPLES deep, read data after MEM_RD_DELAY registers
*/
`timescale 1ns/100ps
`default_nettype none

module pcm_dpram #(
  parameter int NUM_SAMPLES  = 128,
  parameter int MEM_RD_DELAY = 2
) (
  input  logic                             clk,
  input  logic                             wr_en,
  input  logic [$clog2(2*NUM_SAMPLES)-1:0] wr_addr,
  input  acortex_pkg::pcm_word_t           wr_data,
  input  logic [$clog2(2*NUM_SAMPLES)-1:0] rd_addr,
  output acortex_pkg::pcm_word_t           rd_data
);
  import acortex_pkg::*;

  localparam int DEPTH = 2 * NUM_SAMPLES;  // Left and right word per pair

  pcm_word_t mem [DEPTH];
  pcm_word_t rd_pipe [MEM_RD_DELAY];  // Stage 0 is the array read

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Old word on a same-address collision
  always_ff @(posedge clk)
  begin
    rd_pipe[0] <= mem[rd_addr];
    for (int i = 1; i < MEM_RD_DELAY; i++)
    begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[MEM_RD_DELAY-1];

endmodule

`default_nettype wire

// File: common/acortex_pkg.sv
/*
  Shared types of the audio buffering core
  PCM word and stereo pair, local-bus request and response,
  buffer mode enum and the unmapped-read value
*/
`default_nettype none

package acortex_pkg;

  // One PCM sample
  typedef logic [31:0] pcm_word_t;

  // Stereo pair, left in the upper half
  typedef struct packed {
    pcm_word_t left;
    pcm_word_t right;
  } pcm_pair_t;

  typedef logic [7:0]  lb_addr_t;  // Register address
  typedef logic [31:0] lb_data_t;  // Register data

  // Local-bus request, one cycle per access
  typedef struct packed {
    logic     wr_en;
    logic     rd_en;
    lb_addr_t addr;
    lb_data_t wr_data;
  } lb_req_t;

  // Local-bus response
  typedef struct packed {
    logic     wr_valid;  // One cycle after wr_en
    logic     rd_valid;  // Ends each read, with rd_data
    lb_data_t rd_data;
  } lb_rsp_t;

  typedef enum logic {
    MODE_PLAY    = 1'b0,  // Continuous bank swap
    MODE_CAPTURE = 1'b1   // Single frame into bank A
  } bffr_mode_e;

  localparam lb_data_t LB_BAD_DATA = 32'hdeadbabe;  // Unmapped address

endpackage

`default_nettype wire

// File: common/pcm_bffr_regmap.svh
/*
  Local-bus register addresses of the PCM buffer
  Included inside the module body of each user
*/

// Bit 0 holds the mode, a write restarts the frame
localparam logic [7:0] PCM_BFFR_CONTROL_ADDR  = 8'd0;
// Bit 0 holds cap_done
localparam logic [7:0] PCM_BFFR_STATUS_ADDR   = 8'd1;
// Word address into bank A for capture reads
localparam logic [7:0] PCM_BFFR_CAP_ADDR_ADDR = 8'd2;
// Read only, word at CAP_ADDR
localparam logic [7:0] PCM_BFFR_CAP_DATA_ADDR = 8'd3;
